/* common/atom_defines.svh */
`ifndef ATOM_DEFINES_SVH
`define ATOM_DEFINES_SVH

// ========================================
// Clock enable divider
// ========================================

// 25 MHz system clock divided down in 25 states
`define ATOM_CLKDIV_PERIOD 25
// Only the first 16 divider states may carry an enable
`define ATOM_CLKDIV_ACTIVE 16

// ========================================
// Cassette tone
// ========================================

// Enables per tone half period, 16 * 13
`define ATOM_CAS_DIVIDE 208

// ========================================
// Memory map
// ========================================

// Region bases compared against address bits 15..4
`define ATOM_PIA_BASE      12'hB00
`define ATOM_EMPTY_BASE    12'hB40
`define ATOM_ROMLATCH_ADDR 16'hBFFF

// Lock flag in zero page
`define ATOM_LOCK_ADDR 16'h00E7
`define ATOM_LOCK_BIT  5

`endif

/* common/atom_pkg.sv */
package atom_pkg;

   // ========================================
   // Bus widths
   // ========================================

   // CPU address bus
   typedef logic [15:0] addr_t;

   // Data byte on the system bus
   typedef logic [7:0] data_t;

   // External SRAM, 256K bytes
   typedef logic [17:0] sram_addr_t;

   // Speed select
   // 0 is 1 MHz, 1 is 2 MHz, 2 is 4 MHz, 3 is 8 MHz
   typedef logic [1:0] turbo_t;

   // ========================================
   // Bus port FSM
   // ========================================

   typedef enum logic [1:0]
   {
      // Waiting for a request on a CPU enable
      PORT_IDLE,
      // Single cycle with the access on the bus
      PORT_ACCESS,
      // Response held until the master takes it
      PORT_RESPOND
   } port_state_t;

endpackage

/* hw/clock_enables.sv */
`include "atom_defines.svh"

module clock_enables
(
   input  logic             clk25,
   input  logic             reset,
   input  atom_pkg::turbo_t turbo,
   output logic             cpu_clken
);

   // Divider state, 0 to 24
   logic [4:0] clkdiv;
   // Divider in the window that may carry an enable
   logic       active;

   assign active = (clkdiv < 5'(`ATOM_CLKDIV_ACTIVE));

   // ========================================
   // Divider of 25 states
   // ========================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         clkdiv <= '0;
      end
      else if (clkdiv == 5'(`ATOM_CLKDIV_PERIOD - 1))
      begin
         clkdiv <= '0;
      end
      else
      begin
         clkdiv <= clkdiv + 5'd1;
      end
   end

   // ========================================
   // Turbo selection
   // ========================================

   // Fewer low bits checked gives more enables per period
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cpu_clken <= 1'b0;
      end
      else
      begin
         case (turbo)
            // 1 MHz
            2'd0: cpu_clken <= active && (clkdiv[3:0] == 4'd0);
            // 2 MHz
            2'd1: cpu_clken <= active && (clkdiv[2:0] == 3'd0);
            // 4 MHz
            2'd2: cpu_clken <= active && (clkdiv[1:0] == 2'd0);
            // 8 MHz
            default: cpu_clken <= active && !clkdiv[0];
         endcase
      end
   end

endmodule

/* hw/bus_port.sv */
`include "atom_defines.svh"

module bus_port
(
   input  logic            clk25,
   input  logic            reset,
   input  logic            cpu_clken,
   // Request from the external master
   input  logic            req_valid,
   output logic            req_ready,
   input  atom_pkg::addr_t req_addr,
   input  logic            req_rnw,
   input  atom_pkg::data_t req_wdata,
   // Response to the master
   output logic            rsp_valid,
   input  logic            rsp_ready,
   output atom_pkg::data_t rsp_rdata,
   // Access towards the decoder
   output atom_pkg::addr_t acc_addr,
   output logic            acc_rnw,
   output atom_pkg::data_t acc_wdata,
   output logic            acc_strobe,
   input  atom_pkg::data_t acc_rdata,
   // Lock flag snooped from zero page
   output logic            lock
);

   import atom_pkg::*;

   port_state_t state;
   logic        accept;

   // Requests only taken on a CPU enable with the port free
   assign req_ready  = cpu_clken && (state == PORT_IDLE);
   assign accept     = req_valid && req_ready;
   assign acc_strobe = (state == PORT_ACCESS);
   assign rsp_valid  = (state == PORT_RESPOND);

   // ========================================
   // Access FSM and request register
   // ========================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         state     <= PORT_IDLE;
         acc_addr  <= '0;
         acc_rnw   <= 1'b1;
         acc_wdata <= '0;
      end
      else
      begin
         case (state)
            PORT_IDLE:
            begin
               // Latch the request like the registered CPU outputs
               if (accept)
               begin
                  acc_addr  <= req_addr;
                  acc_rnw   <= req_rnw;
                  acc_wdata <= req_wdata;
                  state     <= PORT_ACCESS;
               end
            end
            PORT_ACCESS:
            begin
               state <= PORT_RESPOND;
            end
            PORT_RESPOND:
            begin
               // Hold under back-pressure
               if (rsp_ready)
               begin
                  state <= PORT_IDLE;
               end
            end
            default:
            begin
               state <= PORT_IDLE;
            end
         endcase
      end
   end

   // Read data sampled at the end of the access cycle
   // Writes answer with zero
   always_ff @(posedge clk25)
   begin
      if (acc_strobe)
      begin
         rsp_rdata <= acc_rnw ? acc_rdata : 8'h00;
      end
   end

   // ========================================
   // Lock flag snoop
   // ========================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         lock <= 1'b0;
      end
      else if (acc_strobe && !acc_rnw && (acc_addr == `ATOM_LOCK_ADDR))
      begin
         lock <= acc_wdata[`ATOM_LOCK_BIT];
      end
   end

   // Response must not change while the master stalls
   assert property (@(posedge clk25) disable iff (reset)
      (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata)));

endmodule

/* hw/address_decoder.sv */
`include "atom_defines.svh"

module address_decoder
(
   input  logic                 clk25,
   input  logic                 reset,
   // Access from the bus port
   input  atom_pkg::addr_t      acc_addr,
   input  logic                 acc_rnw,
   input  atom_pkg::data_t      acc_wdata,
   input  logic                 acc_strobe,
   output atom_pkg::data_t      acc_rdata,
   // PIA
   output logic                 pia_sel,
   output logic [1:0]           pia_offset,
   output logic                 pia_we,
   input  atom_pkg::data_t      pia_rdata,
   // External SRAM
   output atom_pkg::sram_addr_t ram_addr,
   output atom_pkg::data_t      ram_wdata,
   input  atom_pkg::data_t      ram_rdata,
   output logic                 ram_we_b,
   output logic                 ram_oe_b,
   output logic                 ram_cs_b
);

   logic       empty_sel;
   logic       latch_sel;
   logic       a000_sel;
   logic       rom_sel;
   logic       wr_cycle;
   // Bank for the A000 window
   logic [2:0] rom_latch;

   // ========================================
   // Region decode
   // ========================================

   // B000-B00F 8255
   assign pia_sel   = (acc_addr[15:4] == `ATOM_PIA_BASE);
   // B400-B40F reads as zero
   assign empty_sel = (acc_addr[15:4] == `ATOM_EMPTY_BASE);
   assign latch_sel = (acc_addr == `ATOM_ROMLATCH_ADDR);
   // A000-AFFF banked window
   assign a000_sel  = (acc_addr[15:12] == 4'hA);
   // C000-FFFF ROM images are write protected
   assign rom_sel   = (acc_addr[15:14] == 2'b11);

   assign wr_cycle   = acc_strobe && !acc_rnw;
   assign pia_we     = wr_cycle;
   assign pia_offset = acc_addr[1:0];

   // ========================================
   // ROM latch at BFFF
   // ========================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         rom_latch <= 3'd0;
      end
      else if (wr_cycle && latch_sel)
      begin
         rom_latch <= acc_wdata[2:0];
      end
   end

   // ========================================
   // External SRAM
   // ========================================

   // Window goes to 01, 0, latch, A11..A0
   assign ram_addr  = a000_sel ? {2'b01, 1'b0, rom_latch, acc_addr[11:0]}
                               : {2'b00, acc_addr};
   assign ram_wdata = acc_wdata;

   // Strobes only in the access cycle
   assign ram_cs_b = !acc_strobe;
   assign ram_oe_b = !(acc_strobe && acc_rnw);
   assign ram_we_b = !(wr_cycle && !rom_sel);

   // Read data mux
   always_comb
   begin
      if (pia_sel)
      begin
         acc_rdata = pia_rdata;
      end
      else if (empty_sel)
      begin
         acc_rdata = 8'h00;
      end
      else
      begin
         acc_rdata = ram_rdata;
      end
   end

   // SRAM write strobe lasts a single cycle
   assert property (@(posedge clk25) disable iff (reset) !ram_we_b |=> ram_we_b);

endmodule

/* pia/pia_8255.sv */
`include "atom_defines.svh"

module pia_8255
(
   input  logic            clk25,
   input  logic            reset,
   input  logic            cpu_clken,
   // Bus side
   input  logic            pia_sel,
   input  logic [1:0]      pia_offset,
   input  logic            pia_we,
   input  atom_pkg::data_t wdata,
   output atom_pkg::data_t pia_rdata,
   // Port inputs
   input  atom_pkg::data_t pb_in,
   input  logic [2:0]      pc_in,
   // Port outputs
   output atom_pkg::data_t pa,
   output logic [3:0]      pc_low,
   output logic            cas_out,
   output logic            sound
);

   import atom_pkg::*;

   // Fixed directions as on the Atom
   data_t      pa_r;
   logic [3:0] pc_r;
   data_t      pc_full;
   logic       wr;
   // Cassette tone
   logic [7:0] cas_div;
   logic       cas_tone;

   assign wr = pia_sel && pia_we;

   // ========================================
   // Port registers
   // ========================================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pa_r <= '0;
         pc_r <= 4'h0;
      end
      else if (wr)
      begin
         case (pia_offset)
            2'd0: pa_r <= wdata;
            2'd2: pc_r <= wdata[3:0];
            2'd3:
            begin
               // Bit set/reset, bit 7 clear only
               if (!wdata[7])
               begin
                  pc_r[wdata[2:1]] <= wdata[0];
               end
            end
            default:
            begin
               // Port B is input only
            end
         endcase
      end
   end

   // Upper PC is inputs and tone
   assign pc_full = {pc_in, cas_tone, pc_r};

   always_comb
   begin
      case (pia_offset)
         2'd0: pia_rdata = pa_r;
         2'd1: pia_rdata = pb_in;
         2'd2: pia_rdata = pc_full;
         default: pia_rdata = 8'h00;
      endcase
   end

   // ========================================
   // Cassette tone and output
   // ========================================

   // Toggles every 208 CPU enables
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= 8'd0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == 8'(`ATOM_CAS_DIVIDE - 1))
         begin
            cas_div  <= 8'd0;
            cas_tone <= !cas_tone;
         end
         else
         begin
            cas_div <= cas_div + 8'd1;
         end
      end
   end

   // Same gating as the two NANDs and inverter on the board
   assign cas_out = !(!(!cas_tone && pc_r[1]) && pc_r[0]);
   assign sound   = pc_r[2];
   assign pa      = pa_r;
   assign pc_low  = pc_r;

endmodule

/* hw/atom_bus_top.sv */
module atom_bus_top
(
   input  logic                 clk25,
   input  logic                 reset,
   // Request port
   input  logic                 req_valid,
   output logic                 req_ready,
   input  atom_pkg::addr_t      req_addr,
   input  logic                 req_rnw,
   input  atom_pkg::data_t      req_wdata,
   // Response port
   output logic                 rsp_valid,
   input  logic                 rsp_ready,
   output atom_pkg::data_t      rsp_rdata,
   // Speed and port inputs
   input  atom_pkg::turbo_t     turbo,
   input  atom_pkg::data_t      pb_in,
   input  logic [2:0]           pc_in,
   // External SRAM
   output atom_pkg::sram_addr_t ram_addr,
   output atom_pkg::data_t      ram_wdata,
   input  atom_pkg::data_t      ram_rdata,
   output logic                 ram_we_b,
   output logic                 ram_oe_b,
   output logic                 ram_cs_b,
   // PIA outputs and flags
   output atom_pkg::data_t      pa,
   output logic [3:0]           pc_low,
   output logic                 cas_out,
   output logic                 sound,
   output logic                 lock
);

   import atom_pkg::*;

   logic       cpu_clken;
   addr_t      acc_addr;
   logic       acc_rnw;
   data_t      acc_wdata;
   logic       acc_strobe;
   data_t      acc_rdata;
   logic       pia_sel;
   logic [1:0] pia_offset;
   logic       pia_we;
   data_t      pia_rdata;

   // ========================================
   // Block instances
   // ========================================

   clock_enables clock_enables_inst
   (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken)
   );

   bus_port bus_port_inst
   (
      .clk25      (clk25),
      .reset      (reset),
      .cpu_clken  (cpu_clken),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req_addr   (req_addr),
      .req_rnw    (req_rnw),
      .req_wdata  (req_wdata),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_rdata  (rsp_rdata),
      .acc_addr   (acc_addr),
      .acc_rnw    (acc_rnw),
      .acc_wdata  (acc_wdata),
      .acc_strobe (acc_strobe),
      .acc_rdata  (acc_rdata),
      .lock       (lock)
   );

   address_decoder address_decoder_inst
   (
      .clk25      (clk25),
      .reset      (reset),
      .acc_addr   (acc_addr),
      .acc_rnw    (acc_rnw),
      .acc_wdata  (acc_wdata),
      .acc_strobe (acc_strobe),
      .acc_rdata  (acc_rdata),
      .pia_sel    (pia_sel),
      .pia_offset (pia_offset),
      .pia_we     (pia_we),
      .pia_rdata  (pia_rdata),
      .ram_addr   (ram_addr),
      .ram_wdata  (ram_wdata),
      .ram_rdata  (ram_rdata),
      .ram_we_b   (ram_we_b),
      .ram_oe_b   (ram_oe_b),
      .ram_cs_b   (ram_cs_b)
   );

   pia_8255 pia_8255_inst
   (
      .clk25      (clk25),
      .reset      (reset),
      .cpu_clken  (cpu_clken),
      .pia_sel    (pia_sel),
      .pia_offset (pia_offset),
      .pia_we     (pia_we),
      .wdata      (acc_wdata),
      .pia_rdata  (pia_rdata),
      .pb_in      (pb_in),
      .pc_in      (pc_in),
      .pa         (pa),
      .pc_low     (pc_low),
      .cas_out    (cas_out),
      .sound      (sound)
   );

endmodule

/* tests/atom_bus_tb.sv */
module atom_bus_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import atom_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int N_RAND = 64;
   // Worst case wait for an enable plus the response
   localparam int ACCESS_CYCLES = 30;
   // Functional accesses plus three throughput windows and the back-pressure hold
   localparam int TEST_CYCLES = (N_RAND * 3 + 40) * ACCESS_CYCLES + 3 * 300 + 100;
   localparam int WATCHDOG_CYCLES = TEST_CYCLES * 2;

   logic       clk25;
   logic       reset;
   logic       req_valid;
   logic       req_ready;
   addr_t      req_addr;
   logic       req_rnw;
   data_t      req_wdata;
   logic       rsp_valid;
   logic       rsp_ready;
   data_t      rsp_rdata;
   turbo_t     turbo;
   data_t      pb_in;
   logic [2:0] pc_in;
   sram_addr_t ram_addr;
   data_t      ram_wdata;
   data_t      ram_rdata;
   logic       ram_we_b;
   logic       ram_oe_b;
   logic       ram_cs_b;
   data_t      pa;
   logic [3:0] pc_low;
   logic       cas_out;
   logic       sound;
   logic       lock;

   // Shadow of the system state
   data_t      shadow_mem [0:262143];
   data_t      shadow_pa;
   logic [3:0] shadow_pc;
   logic [2:0] shadow_latch;
   logic       shadow_lock;

   // Expected responses in issue order
   data_t      exp_q[$];
   data_t      mask_q[$];
   addr_t      addr_q[$];
   data_t      exp_byte;
   data_t      exp_mask;
   addr_t      exp_addr;
   addr_t      cur_addr;
   logic       cur_rnw;
   logic       compare_en;

   integer     seed = 32'hab34;
   int         errors;
   int         test_errors;
   int         tests_run;
   int         tests_failed;
   string      test_name;

   data_t      sram [0:262143];

   atom_bus_top atom_bus_top_inst
   (
      .clk25     (clk25),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req_addr  (req_addr),
      .req_rnw   (req_rnw),
      .req_wdata (req_wdata),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_rdata (rsp_rdata),
      .turbo     (turbo),
      .pb_in     (pb_in),
      .pc_in     (pc_in),
      .ram_addr  (ram_addr),
      .ram_wdata (ram_wdata),
      .ram_rdata (ram_rdata),
      .ram_we_b  (ram_we_b),
      .ram_oe_b  (ram_oe_b),
      .ram_cs_b  (ram_cs_b),
      .pa        (pa),
      .pc_low    (pc_low),
      .cas_out   (cas_out),
      .sound     (sound),
      .lock      (lock)
   );

   always #(CLK_PERIOD / 2) clk25 = ~clk25;

   // ========================================
   // Reference model
   // ========================================

   // Power-up contents depend on every address bit
   function automatic data_t fill_byte(input sram_addr_t a);
      return a[7:0] ^ a[15:8] ^ {4{a[17:16]}};
   endfunction

   // A000-AFFF goes through the bank latch
   function automatic sram_addr_t sram_map(input addr_t addr);
      if (addr[15:12] == 4'hA)
      begin
         return {3'b010, shadow_latch, addr[11:0]};
      end
      return {2'b00, addr};
   endfunction

   function automatic data_t expected_read(input addr_t addr);
      data_t value;
      if (addr[15:4] == 12'hB00)
      begin
         case (addr[1:0])
            2'd0: value = shadow_pa;
            2'd1: value = pb_in;
            // Tone bit masked on compare
            2'd2: value = {pc_in, 1'b0, shadow_pc};
            default: value = 8'h00;
         endcase
      end
      else if (addr[15:4] == 12'hB40)
      begin
         value = 8'h00;
      end
      else
      begin
         value = shadow_mem[sram_map(addr)];
      end
      return value;
   endfunction

   task automatic update_shadow(input addr_t addr, input data_t data);
      // ROM images are write protected
      if (addr[15:14] != 2'b11)
      begin
         shadow_mem[sram_map(addr)] = data;
      end
      if (addr[15:4] == 12'hB00)
      begin
         case (addr[1:0])
            2'd0: shadow_pa = data;
            2'd2: shadow_pc = data[3:0];
            2'd3:
            begin
               if (!data[7])
               begin
                  shadow_pc[data[2:1]] = data[0];
               end
            end
            default:
            begin
            end
         endcase
      end
      if (addr == 16'hBFFF)
      begin
         shadow_latch = data[2:0];
      end
      if (addr == 16'h00E7)
      begin
         shadow_lock = data[5];
      end
   endtask

   // ========================================
   // SRAM model and checkers
   // ========================================

   assign ram_rdata = sram[ram_addr];

   initial
   begin
      for (int i = 0; i < 262144; i++)
      begin
         sram[i] = fill_byte(18'(i));
      end
      forever
      begin
         @(posedge clk25);
         if (!ram_cs_b && !ram_we_b)
         begin
            sram[ram_addr] <= ram_wdata;
         end
      end
   end

   task automatic flag_mismatch(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, expected);
      errors++;
   endtask

   // Handshake completes on the following rising edge
   always @(negedge clk25)
   begin
      if (!reset && compare_en && rsp_valid && rsp_ready)
      begin
         if (exp_q.size() == 0)
         begin
            $display("response at %0t with no access outstanding", $time);
            errors++;
         end
         else
         begin
            exp_byte = exp_q.pop_front();
            exp_mask = mask_q.pop_front();
            exp_addr = addr_q.pop_front();
            if ((rsp_rdata & exp_mask) !== (exp_byte & exp_mask))
            begin
               flag_mismatch($sformatf("response for %h", exp_addr),
                             32'(rsp_rdata), 32'(exp_byte));
            end
         end
      end
   end

   // SRAM pins during the access cycle
   always @(negedge clk25)
   begin
      if (!reset && !ram_cs_b)
      begin
         if (ram_addr !== sram_map(cur_addr))
         begin
            flag_mismatch($sformatf("ram_addr for %h", cur_addr),
                          32'(ram_addr), 32'(sram_map(cur_addr)));
         end
         if (ram_we_b !== (cur_rnw || (cur_addr[15:14] == 2'b11)))
         begin
            flag_mismatch($sformatf("ram_we_b for %h", cur_addr), 32'(ram_we_b),
                          32'(cur_rnw || (cur_addr[15:14] == 2'b11)));
         end
         if (ram_oe_b !== !cur_rnw)
         begin
            flag_mismatch("ram_oe_b", 32'(ram_oe_b), 32'(!cur_rnw));
         end
      end
   end

   // ========================================
   // Bus master
   // ========================================

   // Called right after a rising edge
   task automatic send_request(input addr_t addr, input logic rnw, input data_t data);
      if (rnw)
      begin
         exp_q.push_back(expected_read(addr));
         mask_q.push_back((addr[15:4] == 12'hB00 && addr[1:0] == 2'd2) ? 8'hEF : 8'hFF);
      end
      else
      begin
         exp_q.push_back(8'h00);
         mask_q.push_back(8'hFF);
         update_shadow(addr, data);
      end
      addr_q.push_back(addr);
      cur_addr = addr;
      cur_rnw = rnw;
      req_addr <= addr;
      req_rnw <= rnw;
      req_wdata <= data;
      req_valid <= 1'b1;
      do
      begin
         @(negedge clk25);
      end
      while (!req_ready);
      @(posedge clk25);
      req_valid <= 1'b0;
   endtask

   task automatic wait_response();
      do
      begin
         @(negedge clk25);
      end
      while (!(rsp_valid && rsp_ready));
      @(posedge clk25);
   endtask

   task automatic write_byte(input addr_t addr, input data_t data);
      send_request(addr, 1'b0, data);
      wait_response();
   endtask

   task automatic read_byte(input addr_t addr);
      send_request(addr, 1'b1, 8'h00);
      wait_response();
   endtask

   // Port idle once nothing is on the bus or waiting
   task automatic drain_port();
      do
      begin
         @(negedge clk25);
      end
      while (rsp_valid || !ram_cs_b);
      @(posedge clk25);
   endtask

   task automatic check_ports();
      @(negedge clk25);
      if (pa !== shadow_pa)
      begin
         flag_mismatch("pa", 32'(pa), 32'(shadow_pa));
      end
      if (pc_low !== shadow_pc)
      begin
         flag_mismatch("pc_low", 32'(pc_low), 32'(shadow_pc));
      end
      if (sound !== shadow_pc[2])
      begin
         flag_mismatch("sound", 32'(sound), 32'(shadow_pc[2]));
      end
      if (lock !== shadow_lock)
      begin
         flag_mismatch("lock", 32'(lock), 32'(shadow_lock));
      end
      // Gate fixed unless PC bits 1 and 0 are both set
      if (!(shadow_pc[0] && shadow_pc[1]) && (cas_out !== !shadow_pc[0]))
      begin
         flag_mismatch("cas_out", 32'(cas_out), 32'(!shadow_pc[0]));
      end
      @(posedge clk25);
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_errors = errors;
   endtask

   task automatic report_test();
      tests_run++;
      if (errors == test_errors)
      begin
         $display("test %0d %s: ok", tests_run, test_name);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: FAILED, %0d errors", tests_run, test_name,
                  errors - test_errors);
      end
   endtask

   // ========================================
   // Tests
   // ========================================

   // Anywhere outside the I/O page and the ROM images
   function automatic addr_t pick_ram_addr();
      addr_t addr;
      do
      begin
         addr = 16'($random(seed));
      end
      while (addr[15:12] == 4'hB || addr[15:14] == 2'b11);
      return addr;
   endfunction

   task automatic random_ram_traffic();
      addr_t addr;
      start_test("random RAM traffic");
      for (int i = 0; i < N_RAND; i++)
      begin
         addr = pick_ram_addr();
         write_byte(addr, 8'($random(seed)));
         read_byte(addr);
         // Mostly untouched bytes with their fill values
         read_byte(pick_ram_addr());
      end
      report_test();
   endtask

   task automatic rom_latch_and_mask();
      start_test("ROM latch and write mask");
      write_byte(16'hBFFF, 8'hF5);
      write_byte(16'hA123, 8'h3C);
      read_byte(16'hA123);
      // Other bank at the same window address
      write_byte(16'hBFFF, 8'h02);
      read_byte(16'hA123);
      write_byte(16'hAFFF, 8'hC3);
      read_byte(16'hAFFF);
      write_byte(16'hBFFF, 8'h05);
      read_byte(16'hA123);
      read_byte(16'hBFFF);
      // Masked writes leave the SRAM alone
      write_byte(16'hC000, 8'h99);
      read_byte(16'hC000);
      write_byte(16'hFFFE, 8'h11);
      read_byte(16'hFFFE);
      write_byte(16'hBFFF, 8'h00);
      report_test();
   endtask

   task automatic pia_registers();
      start_test("PIA registers");
      pb_in <= 8'hA7;
      pc_in <= 3'b101;
      write_byte(16'hB000, 8'h5A);
      read_byte(16'hB000);
      write_byte(16'hB002, 8'hF5);
      read_byte(16'hB002);
      check_ports();
      // Set bit 3, clear bit 2, then a mode word
      write_byte(16'hB003, 8'h07);
      write_byte(16'hB003, 8'h04);
      write_byte(16'hB003, 8'h83);
      read_byte(16'hB002);
      read_byte(16'hB001);
      read_byte(16'hB003);
      read_byte(16'hB400);
      read_byte(16'hB40F);
      check_ports();
      report_test();
   endtask

   task automatic lock_and_cassette();
      start_test("lock snoop and cassette output");
      write_byte(16'h00E7, 8'h20);
      check_ports();
      write_byte(16'h00E7, 8'hDF);
      check_ports();
      write_byte(16'h00E7, 8'hFF);
      check_ports();
      write_byte(16'h00E7, 8'h00);
      read_byte(16'h00E7);
      check_ports();
      // Tone independent gate settings
      write_byte(16'hB002, 8'h00);
      check_ports();
      write_byte(16'hB002, 8'h02);
      check_ports();
      write_byte(16'hB002, 8'h01);
      check_ports();
      write_byte(16'hB002, 8'h00);
      report_test();
   endtask

   task automatic count_accepts(output int accepts);
      int count;
      count = 0;
      // New speed settles within a divider period
      repeat (30) @(posedge clk25);
      cur_addr = 16'h0100;
      cur_rnw = 1'b1;
      req_addr <= 16'h0100;
      req_rnw <= 1'b1;
      req_valid <= 1'b1;
      repeat (250)
      begin
         @(negedge clk25);
         if (req_ready)
         begin
            count++;
         end
      end
      @(posedge clk25);
      req_valid <= 1'b0;
      drain_port();
      accepts = count;
   endtask

   task automatic throughput_and_backpressure();
      int    accepts;
      data_t held;
      start_test("throughput and back-pressure");
      compare_en = 1'b0;
      for (int t = 0; t < 3; t++)
      begin
         turbo <= 2'(t);
         count_accepts(accepts);
         if (accepts != (10 << t))
         begin
            flag_mismatch($sformatf("acceptances at turbo %0d", t), 32'(accepts),
                          32'(10 << t));
         end
      end
      compare_en = 1'b1;
      turbo <= 2'd2;
      rsp_ready <= 1'b0;
      send_request(16'h0345, 1'b1, 8'h00);
      do
      begin
         @(negedge clk25);
      end
      while (!rsp_valid);
      held = rsp_rdata;
      // Response frozen while the master stalls
      repeat (20)
      begin
         @(negedge clk25);
         if (!rsp_valid || rsp_rdata !== held || req_ready)
         begin
            flag_mismatch("stalled response valid, data, ready",
                          {23'd0, rsp_valid, rsp_rdata}, {23'd0, 1'b1, held});
            if (req_ready)
            begin
               $display("req_ready went high at %0t during a stalled response", $time);
            end
         end
      end
      @(posedge clk25);
      rsp_ready <= 1'b1;
      wait_response();
      report_test();
   endtask

   // ========================================
   // Sequence and watchdog
   // ========================================

   initial
   begin
      clk25 = 1'b0;
      reset = 1'b1;
      req_valid = 1'b0;
      req_addr = '0;
      req_rnw = 1'b1;
      req_wdata = '0;
      rsp_ready = 1'b1;
      turbo = 2'd2;
      pb_in = 8'h00;
      pc_in = 3'd0;
      compare_en = 1'b1;
      cur_addr = '0;
      cur_rnw = 1'b1;
      errors = 0;
      tests_run = 0;
      tests_failed = 0;
      for (int i = 0; i < 262144; i++)
      begin
         shadow_mem[i] = fill_byte(18'(i));
      end
      shadow_pa = '0;
      shadow_pc = '0;
      shadow_latch = '0;
      shadow_lock = 1'b0;
      repeat (4) @(posedge clk25);
      reset <= 1'b0;
      @(posedge clk25);
      check_ports();
      random_ram_traffic();
      rom_latch_and_mask();
      pia_registers();
      lock_and_cassette();
      throughput_and_backpressure();
      if (exp_q.size() != 0)
      begin
         $display("%0d responses never arrived", exp_q.size());
         errors++;
      end
      $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
      begin
         $display("Regression passed");
      end
      else
      begin
         $display("Regression failed");
      end
      $finish;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule

/* sources.f */
+incdir+common
common/atom_pkg.sv
hw/clock_enables.sv
hw/bus_port.sv
hw/address_decoder.sv
pia/pia_8255.sv
hw/atom_bus_top.sv
tests/atom_bus_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module atom_bus_tb \
      -f sources.f -o atom_bus_sim; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/atom_bus_sim > "$log" 2>&1; then
   cat "$log"
   echo "Simulation exited with an error"
   exit 1
fi
cat "$log"

if grep -q "Regression failed" "$log"; then
   exit 1
fi
exit 0
